/* source/adc_cfg_pkg.sv */
package adc_cfg_pkg;

  // serial word layout, address in the top bits
  localparam int ADDR_W  = 3;
  localparam int DATA_W  = 16;
  localparam int FRAME_W = ADDR_W + DATA_W;

  // one serial clock period is 2**SCLK_DIV_W clk cycles
  localparam int SCLK_DIV_W = 3;
  localparam int BIT_CNT_W  = 5;  // counts the 19 data periods
  localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(FRAME_W - 1);

  // mode pin settle countdown, mode rises below half range
  localparam int SETTLE_W = 6;

  // boot configuration words, both go to address 0
  localparam logic [ADDR_W-1:0] BOOT_ADDR        = '0;
  localparam logic [DATA_W-1:0] BOOT_WORD_SINGLE = 16'h7cbc;
  localparam logic [DATA_W-1:0] BOOT_WORD_ILV    = 16'h7c2c;

  // clock manager reset stretch after ddrb falls
  localparam int DCM_EXT_LEN = 5;

  // serial transmitter frame states
  localparam int TX_STATE_W = 3;
  localparam logic [TX_STATE_W-1:0] TX_IDLE   = 3'd0;  // nothing to send
  localparam logic [TX_STATE_W-1:0] TX_WAIT   = 3'd1;  // align to sclk falling edge
  localparam logic [TX_STATE_W-1:0] TX_STRB0  = 3'd2;  // strobe still high
  localparam logic [TX_STATE_W-1:0] TX_DATA   = 3'd3;  // 19 bit periods
  localparam logic [TX_STATE_W-1:0] TX_COMMIT = 3'd4;  // commit period
  localparam logic [TX_STATE_W-1:0] TX_STRB1  = 3'd5;  // strobe back high
  localparam logic [TX_STATE_W-1:0] TX_SWAIT  = 3'd6;  // gap before idle

  // boot sequencer states
  localparam int BOOT_STATE_W = 3;
  localparam logic [BOOT_STATE_W-1:0] BOOT_MODE_CLR = 3'd0;
  localparam logic [BOOT_STATE_W-1:0] BOOT_MODE_SET = 3'd1;
  localparam logic [BOOT_STATE_W-1:0] BOOT_LOAD     = 3'd2;
  localparam logic [BOOT_STATE_W-1:0] BOOT_WAIT     = 3'd3;
  localparam logic [BOOT_STATE_W-1:0] BOOT_RESET    = 3'd4;
  localparam logic [BOOT_STATE_W-1:0] BOOT_DONE     = 3'd5;

endpackage

/* source/three_wire_tx.sv */
`timescale 1ns/100ps

module three_wire_tx (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             start_i,
  input  logic [adc_cfg_pkg::FRAME_W-1:0]  word_i,
  output logic                             busy_o,
  output logic                             sclk_o,
  output logic                             strb_o,
  output logic                             sdata_o
);

  logic [adc_cfg_pkg::SCLK_DIV_W-1:0] div_cnt;
  logic                               div_wrap;
  logic [adc_cfg_pkg::TX_STATE_W-1:0] state;
  logic [adc_cfg_pkg::BIT_CNT_W-1:0]  bit_cnt;
  logic [adc_cfg_pkg::FRAME_W-1:0]    shift_reg;
  logic                               clk_active;

  // free running divider, wraps on its own
  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign div_wrap = &div_cnt;  // last cycle before sclk falls

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= adc_cfg_pkg::TX_IDLE;
      bit_cnt   <= '0;
      shift_reg <= '0;  // keeps sdata low out of reset
    end else begin
      if (start_i && state == adc_cfg_pkg::TX_IDLE) begin
        shift_reg <= word_i;  // msb goes out first
        bit_cnt   <= '0;
        state     <= adc_cfg_pkg::TX_WAIT;
      end
      if (div_wrap) begin
        case (state)
          adc_cfg_pkg::TX_WAIT: begin
            state <= adc_cfg_pkg::TX_STRB0;
          end
          adc_cfg_pkg::TX_STRB0: begin
            state <= adc_cfg_pkg::TX_DATA;
          end
          adc_cfg_pkg::TX_DATA: begin
            shift_reg <= {shift_reg[adc_cfg_pkg::FRAME_W-2:0], 1'b0};
            bit_cnt   <= bit_cnt + 1'b1;
            if (bit_cnt == adc_cfg_pkg::LAST_BIT) begin
              state <= adc_cfg_pkg::TX_COMMIT;
            end
          end
          adc_cfg_pkg::TX_COMMIT: begin
            state <= adc_cfg_pkg::TX_STRB1;
          end
          adc_cfg_pkg::TX_STRB1: begin
            state <= adc_cfg_pkg::TX_SWAIT;
          end
          adc_cfg_pkg::TX_SWAIT: begin
            state <= adc_cfg_pkg::TX_IDLE;
          end
          default: begin
          end
        endcase
      end
    end
  end

  assign clk_active = (state != adc_cfg_pkg::TX_IDLE) && (state != adc_cfg_pkg::TX_WAIT);

  assign busy_o  = state != adc_cfg_pkg::TX_IDLE;
  assign sclk_o  = clk_active ? div_cnt[adc_cfg_pkg::SCLK_DIV_W-1] : 1'b0;
  assign strb_o  = !(state == adc_cfg_pkg::TX_DATA || state == adc_cfg_pkg::TX_COMMIT);
  assign sdata_o = shift_reg[adc_cfg_pkg::FRAME_W-1];

endmodule

/* source/adc_boot_seq.sv */
`timescale 1ns/100ps

module adc_boot_seq #(
  parameter bit INTERLEAVED = 1'b0
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            tx_busy_i,
  output logic                            start_o,
  output logic [adc_cfg_pkg::ADDR_W-1:0]  addr_o,
  output logic [adc_cfg_pkg::DATA_W-1:0]  data_o,
  output logic                            mode_o,
  output logic                            ddrb_o,
  output logic                            done_o
);

  logic [adc_cfg_pkg::BOOT_STATE_W-1:0] state;
  logic [adc_cfg_pkg::SETTLE_W-1:0]     settle_cnt;

  // the mode line is heavily loaded, so the settle time is long in hardware
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= adc_cfg_pkg::BOOT_MODE_CLR;
      settle_cnt <= '1;
    end else begin
      case (state)
        adc_cfg_pkg::BOOT_MODE_CLR: begin
          if (settle_cnt == '0) begin
            state <= adc_cfg_pkg::BOOT_MODE_SET;
          end else begin
            settle_cnt <= settle_cnt - 1'b1;
          end
        end
        adc_cfg_pkg::BOOT_MODE_SET: begin
          state <= adc_cfg_pkg::BOOT_LOAD;
        end
        adc_cfg_pkg::BOOT_LOAD: begin
          state <= adc_cfg_pkg::BOOT_WAIT;  // tx picks the word up here
        end
        adc_cfg_pkg::BOOT_WAIT: begin
          if (!tx_busy_i) begin
            state <= adc_cfg_pkg::BOOT_RESET;
          end
        end
        adc_cfg_pkg::BOOT_RESET: begin
          state <= adc_cfg_pkg::BOOT_DONE;
        end
        default: begin
        end
      endcase
    end
  end

  // mode rises once the countdown drops below half range
  assign mode_o  = !settle_cnt[adc_cfg_pkg::SETTLE_W-1];
  assign start_o = state == adc_cfg_pkg::BOOT_LOAD;
  assign ddrb_o  = state == adc_cfg_pkg::BOOT_RESET;  // single cycle pulse
  assign done_o  = state == adc_cfg_pkg::BOOT_DONE;
  assign addr_o  = adc_cfg_pkg::BOOT_ADDR;
  assign data_o  = INTERLEAVED ? adc_cfg_pkg::BOOT_WORD_ILV : adc_cfg_pkg::BOOT_WORD_SINGLE;

endmodule

/* source/adc_cfg_arbiter.sv */
`timescale 1ns/100ps

module adc_cfg_arbiter (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             boot_done_i,
  input  logic                             host_sel_i,
  input  logic                             host_wr_i,
  input  logic [adc_cfg_pkg::ADDR_W-1:0]   host_addr_i,
  input  logic [adc_cfg_pkg::DATA_W-1:0]   host_data_i,
  input  logic                             host_mode_i,
  input  logic                             host_ddrb_i,
  input  logic                             boot_start_i,
  input  logic [adc_cfg_pkg::ADDR_W-1:0]   boot_addr_i,
  input  logic [adc_cfg_pkg::DATA_W-1:0]   boot_data_i,
  input  logic                             boot_mode_i,
  input  logic                             boot_ddrb_i,
  input  logic                             tx_busy_i,
  output logic                             tx_start_o,
  output logic [adc_cfg_pkg::FRAME_W-1:0]  tx_word_o,
  output logic                             mode_o,
  output logic                             ddrb_o,
  output logic                             credit_o
);

  logic host_ctl;
  logic host_xfer;  // running transfer belongs to the host
  logic busy_q;

  assign host_ctl = host_sel_i && boot_done_i;  // host only after boot

  assign mode_o     = host_ctl ? host_mode_i : boot_mode_i;
  assign ddrb_o     = host_ctl ? host_ddrb_i : boot_ddrb_i;
  assign tx_start_o = (host_ctl ? host_wr_i : boot_start_i) && !tx_busy_i;
  assign tx_word_o  = host_ctl ? {host_addr_i, host_data_i} : {boot_addr_i, boot_data_i};

  // credit goes back one cycle after the frame has fully ended
  always_ff @(posedge clk) begin
    if (rst) begin
      host_xfer <= 1'b0;
      busy_q    <= 1'b0;
      credit_o  <= 1'b0;
    end else begin
      busy_q   <= tx_busy_i;
      credit_o <= host_xfer && busy_q && !tx_busy_i;
      if (tx_start_o) begin
        host_xfer <= host_ctl;
      end else if (busy_q && !tx_busy_i) begin
        host_xfer <= 1'b0;
      end
    end
  end

endmodule

/* source/ddrb_pulse_ext.sv */
`timescale 1ns/100ps

module ddrb_pulse_ext (
  input  logic clk,
  input  logic rst,
  input  logic ddrb_i,
  output logic ddrb_o,
  output logic dcm_reset_o
);

  logic [adc_cfg_pkg::DCM_EXT_LEN-1:0] ext_sr;

  always_ff @(posedge clk) begin
    if (rst) begin
      ddrb_o <= 1'b0;
      ext_sr <= '0;
    end else begin
      ddrb_o <= ddrb_i;  // meant to sit in the io register
      if (ddrb_i) begin
        ext_sr <= '1;  // refill while ddrb is high
      end else begin
        ext_sr <= {ext_sr[adc_cfg_pkg::DCM_EXT_LEN-2:0], 1'b0};
      end
    end
  end

  assign dcm_reset_o = ext_sr[adc_cfg_pkg::DCM_EXT_LEN-1];

endmodule

/* source/adc_cfg_top.sv */
`timescale 1ns/100ps

module adc_cfg_top #(
  parameter bit INTERLEAVED = 1'b0
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            host_sel_i,
  input  logic                            host_wr_i,
  input  logic [adc_cfg_pkg::ADDR_W-1:0]  host_addr_i,
  input  logic [adc_cfg_pkg::DATA_W-1:0]  host_data_i,
  input  logic                            host_mode_i,
  input  logic                            host_ddrb_i,
  output logic                            credit_o,
  output logic                            boot_done_o,
  output logic                            mode_o,
  output logic                            ddrb_o,
  output logic                            dcm_reset_o,
  output logic                            ctrl_clk_o,
  output logic                            ctrl_strb_o,
  output logic                            ctrl_data_o
);

  logic                           boot_start;
  logic [adc_cfg_pkg::ADDR_W-1:0] boot_addr;
  logic [adc_cfg_pkg::DATA_W-1:0] boot_data;
  logic                           boot_mode;
  logic                           boot_ddrb;
  logic                           tx_busy;
  logic                           tx_start;
  logic [adc_cfg_pkg::FRAME_W-1:0] tx_word;
  logic                           ddrb_int;  // muxed ddrb before the pad register

  adc_boot_seq #(
    .INTERLEAVED (INTERLEAVED)
  ) i_adc_boot_seq (
    .clk       (clk),
    .rst       (rst),
    .tx_busy_i (tx_busy),
    .start_o   (boot_start),
    .addr_o    (boot_addr),
    .data_o    (boot_data),
    .mode_o    (boot_mode),
    .ddrb_o    (boot_ddrb),
    .done_o    (boot_done_o)
  );

  adc_cfg_arbiter i_adc_cfg_arbiter (
    .clk          (clk),
    .rst          (rst),
    .boot_done_i  (boot_done_o),
    .host_sel_i   (host_sel_i),
    .host_wr_i    (host_wr_i),
    .host_addr_i  (host_addr_i),
    .host_data_i  (host_data_i),
    .host_mode_i  (host_mode_i),
    .host_ddrb_i  (host_ddrb_i),
    .boot_start_i (boot_start),
    .boot_addr_i  (boot_addr),
    .boot_data_i  (boot_data),
    .boot_mode_i  (boot_mode),
    .boot_ddrb_i  (boot_ddrb),
    .tx_busy_i    (tx_busy),
    .tx_start_o   (tx_start),
    .tx_word_o    (tx_word),
    .mode_o       (mode_o),
    .ddrb_o       (ddrb_int),
    .credit_o     (credit_o)
  );

  three_wire_tx i_three_wire_tx (
    .clk     (clk),
    .rst     (rst),
    .start_i (tx_start),
    .word_i  (tx_word),
    .busy_o  (tx_busy),
    .sclk_o  (ctrl_clk_o),
    .strb_o  (ctrl_strb_o),
    .sdata_o (ctrl_data_o)
  );

  ddrb_pulse_ext i_ddrb_pulse_ext (
    .clk         (clk),
    .rst         (rst),
    .ddrb_i      (ddrb_int),
    .ddrb_o      (ddrb_o),
    .dcm_reset_o (dcm_reset_o)
  );

endmodule

/* tb/tb_adc_cfg_top.sv */
`timescale 1ns/100ps

module tb_adc_cfg_top;

  localparam int PERIOD_CYC   = 2 ** adc_cfg_pkg::SCLK_DIV_W;  // clk cycles per serial bit
  localparam int FRAME_CYC    = 25 * PERIOD_CYC;  // longest frame
  localparam int SETTLE_CYC   = 2 ** adc_cfg_pkg::SETTLE_W;
  localparam int N_HOST_WR    = 3;
  localparam int MAX_CYCLES   = 3 * ((N_HOST_WR + 1) * FRAME_CYC + SETTLE_CYC);
  localparam int STRB_LOW_CYC = (adc_cfg_pkg::FRAME_W + 1) * PERIOD_CYC;  // data plus commit

  logic                           clk;
  logic                           rst;
  logic                           host_sel_i;
  logic                           host_wr_i;
  logic [adc_cfg_pkg::ADDR_W-1:0] host_addr_i;
  logic [adc_cfg_pkg::DATA_W-1:0] host_data_i;
  logic                           host_mode_i;
  logic                           host_ddrb_i;
  logic credit_o, boot_done_o, mode_o, ddrb_o, dcm_reset_o;
  logic ctrl_clk_o, ctrl_strb_o, ctrl_data_o;

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err0 = 0;
  int cycle_cnt = 0;
  logic [31:0] lfsr = 32'hfc47_250c;

  logic [adc_cfg_pkg::FRAME_W-1:0] shift_word;
  logic [adc_cfg_pkg::FRAME_W-1:0] frames[$];  // decoded serial words in order
  int   n_bits = 0;
  int   strb_low_len = 0;
  int   ddrb_rises = 0;
  int   ddrb_low = adc_cfg_pkg::DCM_EXT_LEN;  // cycles since ddrb_o was last high
  int   credit_cnt = 0;
  logic sclk_q, strb_q, ddrb_q, host_ctl_q, host_ddrb_q;
  logic exp_dcm;

  adc_cfg_top #(
    .INTERLEAVED (1'b0)
  ) i_adc_cfg_top (
    .clk         (clk),
    .rst         (rst),
    .host_sel_i  (host_sel_i),
    .host_wr_i   (host_wr_i),
    .host_addr_i (host_addr_i),
    .host_data_i (host_data_i),
    .host_mode_i (host_mode_i),
    .host_ddrb_i (host_ddrb_i),
    .credit_o    (credit_o),
    .boot_done_o (boot_done_o),
    .mode_o      (mode_o),
    .ddrb_o      (ddrb_o),
    .dcm_reset_o (dcm_reset_o),
    .ctrl_clk_o  (ctrl_clk_o),
    .ctrl_strb_o (ctrl_strb_o),
    .ctrl_data_o (ctrl_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
    errors++;
  endtask

  task automatic report_issue(input string what);
    $display("Error at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else report_value(name, exp, got);
  endtask

  // 32 bit fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors > test_err0) begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - test_err0);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    test_err0 = errors;
  endtask

  // spends the credit, then waits for it to come back
  task automatic host_write(input logic [adc_cfg_pkg::ADDR_W-1:0] addr,
                            input logic [adc_cfg_pkg::DATA_W-1:0] data);
    int n_frames;
    int credit0;
    n_frames = frames.size();
    credit0  = credit_cnt;
    @(posedge clk);
    #1;
    host_wr_i   = 1'b1;
    host_addr_i = addr;
    host_data_i = data;
    @(posedge clk);
    #1;
    host_wr_i = 1'b0;
    while (credit_cnt == credit0) @(negedge clk);
    check_value("frame count", n_frames + 1, frames.size());
    if (frames.size() > n_frames) check_value("ctrl frame", {addr, data}, frames[n_frames]);
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (ctrl_clk_o && !sclk_q && !ctrl_strb_o) begin
        if (n_bits < adc_cfg_pkg::FRAME_W) begin
          shift_word = {shift_word[adc_cfg_pkg::FRAME_W-2:0], ctrl_data_o};
        end
        n_bits++;
      end
      if (!ctrl_strb_o) strb_low_len++;
      if (ctrl_strb_o && !strb_q) begin  // strobe back high ends the frame
        assert (strb_low_len == STRB_LOW_CYC)
          else report_value("strobe low cycles", STRB_LOW_CYC, strb_low_len);
        assert (n_bits == adc_cfg_pkg::FRAME_W + 1)
          else report_value("sclk edges", adc_cfg_pkg::FRAME_W + 1, n_bits);
        frames.push_back(shift_word);
        n_bits       = 0;
        strb_low_len = 0;
      end
      if (ddrb_o && !ddrb_q) ddrb_rises++;
      if (ddrb_o) ddrb_low = 0;
      else if (ddrb_low < adc_cfg_pkg::DCM_EXT_LEN) ddrb_low++;
      // ddrb_o lags the internal ddrb by one cycle, so the stretch looks one shorter here
      exp_dcm = ddrb_o || (ddrb_low >= 1 && ddrb_low < adc_cfg_pkg::DCM_EXT_LEN);
      assert (dcm_reset_o == exp_dcm) else report_value("dcm_reset_o", exp_dcm, dcm_reset_o);
      if (host_ctl_q) begin
        assert (ddrb_o == host_ddrb_q) else report_value("ddrb_o", host_ddrb_q, ddrb_o);
      end
      if (host_sel_i && boot_done_o) begin
        assert (mode_o == host_mode_i) else report_value("mode_o", host_mode_i, mode_o);
      end
      if (credit_o) begin
        credit_cnt++;
      end
    end
    sclk_q      = ctrl_clk_o;
    strb_q      = ctrl_strb_o;
    ddrb_q      = ddrb_o;
    host_ctl_q  = host_sel_i && boot_done_o;
    host_ddrb_q = host_ddrb_i;
  end

  assert property (@(posedge clk) disable iff (rst) (!boot_done_o && $past(mode_o)) |-> mode_o)
    else report_value("mode_o", 1, 0);
  assert property (@(posedge clk) disable iff (rst) !boot_done_o |-> !credit_o)
    else report_value("credit_o", 0, 1);
  assert property (@(posedge clk) disable iff (rst) credit_o |=> !credit_o)
    else report_issue("credit_o stayed high for more than one cycle");

  initial begin
    logic [31:0] r_addr;
    logic [31:0] r_data;
    rst = 1'b1;
    host_sel_i = 1'b0;
    host_wr_i = 1'b0;
    host_addr_i = '0;
    host_data_i = '0;
    host_mode_i = 1'b0;
    host_ddrb_i = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value("mode_o", 0, mode_o);
    check_value("ctrl_clk_o", 0, ctrl_clk_o);
    check_value("ctrl_data_o", 0, ctrl_data_o);
    check_value("ctrl_strb_o", 1, ctrl_strb_o);
    check_value("ddrb_o", 0, ddrb_o);
    check_value("dcm_reset_o", 0, dcm_reset_o);
    check_value("credit_o", 0, credit_o);
    check_value("boot_done_o", 0, boot_done_o);
    while (ctrl_strb_o) @(negedge clk);  // first frame starts
    check_value("mode_o", 1, mode_o);
    end_test("mode pin before boot write");

    while (!boot_done_o) @(negedge clk);
    repeat (2) @(negedge clk);
    check_value("frame count", 1, frames.size());
    if (frames.size() > 0) begin
      check_value("ctrl frame", {3'd0, adc_cfg_pkg::BOOT_WORD_SINGLE}, frames[0]);
    end
    check_value("ddrb pulses", 1, ddrb_rises);
    end_test("boot write and ddrb pulse");

    repeat (adc_cfg_pkg::DCM_EXT_LEN + 2) @(negedge clk);
    check_value("dcm_reset_o", 0, dcm_reset_o);
    end_test("dcm reset stretch");

    @(posedge clk);
    #1;
    host_mode_i = 1'b1;  // keep the mode pin up across the handover
    host_sel_i  = 1'b1;
    for (int i = 0; i < N_HOST_WR; i++) begin
      random_bits(adc_cfg_pkg::ADDR_W, r_addr);
      random_bits(adc_cfg_pkg::DATA_W, r_data);
      host_write(r_addr[adc_cfg_pkg::ADDR_W-1:0], r_data[adc_cfg_pkg::DATA_W-1:0]);
    end
    end_test("host writes");

    repeat (4) @(negedge clk);
    check_value("credit pulses", N_HOST_WR, credit_cnt);
    end_test("credit return");

    @(posedge clk);
    #1;
    host_ddrb_i = 1'b1;
    host_mode_i = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    host_ddrb_i = 1'b0;
    host_mode_i = 1'b1;
    repeat (adc_cfg_pkg::DCM_EXT_LEN + 3) @(negedge clk);
    check_value("ddrb pulses", 2, ddrb_rises);
    check_value("dcm_reset_o", 0, dcm_reset_o);
    end_test("host ddrb and mode");

    $display("%0d tests run, %0d tests failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* project.f */
source/adc_cfg_pkg.sv
source/three_wire_tx.sv
source/adc_boot_seq.sv
source/adc_cfg_arbiter.sv
source/ddrb_pulse_ext.sv
source/adc_cfg_top.sv
tb/tb_adc_cfg_top.sv
